/* include/gpio_config.svh */
// gpio peripheral configuration macros
// bank and bus widths, register offsets per peer,
// region select values on the top two bus address bits
`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

// ---------------------------------------------------------------------------
// widths
// ---------------------------------------------------------------------------
`define GPIO_BANK_W   16          // pins per bank
`define GPIO_LADDR_W  6           // local register address
`define GPIO_PADDR_W  8           // apb address, top two bits pick the region

// bank register offsets
`define GPR_DIRECTION_MODE  6'h04 // 1 = input, 0 = output
`define GPR_OUTPUT_ENABLE   6'h08 // drive enable per pin
`define GPR_OUTPUT_VALUE    6'h0C // value put on the pins
`define GPR_INPUT_VALUE     6'h10 // synchronised pin value, read only
`define GPR_INT_STATUS      6'h20 // rising edge status, clear on read

// interrupt controller offsets
`define GPR_IRQ_MASK        6'h00 // bank mask in bits 1:0
`define GPR_IRQ_PENDING     6'h04 // one pending bit per bank

// region select, value 3 is unmapped
`define GPIO_REGION_BANK0   2'd0
`define GPIO_REGION_BANK1   2'd1
`define GPIO_REGION_IRQ     2'd2

`endif

/* source/gpio_pkg.sv */
// shared types for the gpio peripheral
// pin words, local register addresses and apb addresses
`include "gpio_config.svh"

package gpio_pkg;

  // one bank worth of pins, also the register data width
  typedef logic [`GPIO_BANK_W-1:0] gpio_word_t;

  // register offset inside a peer
  typedef logic [`GPIO_LADDR_W-1:0] gpio_laddr_t;

  // full apb address incl. region bits
  typedef logic [`GPIO_PADDR_W-1:0] gpio_paddr_t;

endpackage

/* source/gpio_apb_slave.sv */
// apb slave for the gpio peripheral
// region decode, read strobes in setup, write strobes in access,
// read data merge, pready and pslverr generation
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_apb_slave
  import gpio_pkg::*;
(
  input  logic        pclk28,
  input  logic        n_reset28,     // async, active low
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  gpio_paddr_t paddr,
  input  gpio_word_t  pwdata,
  input  gpio_word_t  bank0_rdata,   // zero unless strobed
  input  gpio_word_t  bank1_rdata,
  input  gpio_word_t  irq_rdata,
  output gpio_word_t  prdata,
  output logic        pready,
  output logic        pslverr,
  output gpio_laddr_t addr,
  output gpio_word_t  wdata,
  output logic        bank0_read,
  output logic        bank0_write,
  output logic        bank1_read,
  output logic        bank1_write,
  output logic        irq_read,
  output logic        irq_write
);

  logic [1:0] region;               // top two address bits
  logic       hit_bank0;
  logic       hit_bank1;
  logic       hit_irq;
  logic       setup_ph;             // psel without penable
  logic       access_ph;            // psel and penable
  logic       unmapped_q;           // setup phase went to region 3

  // ---------------------------------------------------------------------------
  // decode
  // ---------------------------------------------------------------------------
  assign region    = paddr[`GPIO_PADDR_W-1 -: 2];
  assign hit_bank0 = (region == `GPIO_REGION_BANK0);
  assign hit_bank1 = (region == `GPIO_REGION_BANK1);
  assign hit_irq   = (region == `GPIO_REGION_IRQ);

  assign setup_ph  = psel & ~penable;
  assign access_ph = psel & penable;

  assign addr  = paddr[`GPIO_LADDR_W-1:0];  // local offset only
  assign wdata = pwdata;

  // peers register read data on this edge
  assign bank0_read  = setup_ph & ~pwrite & hit_bank0;
  assign bank1_read  = setup_ph & ~pwrite & hit_bank1;
  assign irq_read    = setup_ph & ~pwrite & hit_irq;

  // write lands at the end of access
  assign bank0_write = access_ph & pwrite & hit_bank0;
  assign bank1_write = access_ph & pwrite & hit_bank1;
  assign irq_write   = access_ph & pwrite & hit_irq;

  // remember an unmapped setup so access needs no second decode
  always_ff @(posedge pclk28 or negedge n_reset28)
  begin
    if (!n_reset28)
      unmapped_q <= 1'b0;
    else
      unmapped_q <= setup_ph & ~(hit_bank0 | hit_bank1 | hit_irq);
  end

  // ---------------------------------------------------------------------------
  // response
  // ---------------------------------------------------------------------------
  assign pready  = access_ph;                 // no wait states
  assign pslverr = access_ph & unmapped_q;
  assign prdata  = (bank0_rdata | bank1_rdata | irq_rdata)
                 & {`GPIO_BANK_W{access_ph & ~pwrite}};

endmodule

/* source/gpio_lite_subunit.sv */
// one 16-pin gpio bank
// direction, output enable and output value registers,
// two-stage input synchroniser and input value register,
// rising edge interrupt status with clear on read, pin drive
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_lite_subunit
  import gpio_pkg::*;
(
  input  logic        pclk28,
  input  logic        n_reset28,         // async, active low
  input  logic        read,              // setup cycle of a read
  input  logic        write,             // access cycle of a write
  input  gpio_laddr_t addr,
  input  gpio_word_t  wdata,
  input  gpio_word_t  pin_in,            // raw, asynchronous
  input  gpio_word_t  tri_state_enable,  // dft, forces hi-z
  output gpio_word_t  interrupt,
  output gpio_word_t  rdata,
  output gpio_word_t  pin_oe_n,
  output gpio_word_t  pin_out
);

  gpio_word_t direction_mode;   // 1 = input
  gpio_word_t output_enable;
  gpio_word_t output_value;
  gpio_word_t input_value;      // third stage after the synchroniser
  gpio_word_t input_prev;       // input_value one edge later, edge detect
  gpio_word_t int_status;
  gpio_word_t sync_one;         // first flop, next to the pin
  gpio_word_t sync_two;
  gpio_word_t int_event;        // rising edge seen on input_value
  gpio_word_t int_trigger;      // edge on an input-mode pin
  logic       status_clear;

  // ---------------------------------------------------------------------------
  // control registers
  // ---------------------------------------------------------------------------
  always_ff @(posedge pclk28 or negedge n_reset28)
  begin
    if (!n_reset28)
    begin
      direction_mode <= '0;     // all outputs
      output_enable  <= '0;     // but none driven
      output_value   <= '0;
    end
    else if (write)
    begin
      if (addr == `GPR_DIRECTION_MODE)
        direction_mode <= wdata;
      if (addr == `GPR_OUTPUT_ENABLE)
        output_enable <= wdata;
      if (addr == `GPR_OUTPUT_VALUE)
        output_value <= wdata;
    end
  end

  // ---------------------------------------------------------------------------
  // input path
  // ---------------------------------------------------------------------------
  // pin to input_value takes three edges
  always_ff @(posedge pclk28 or negedge n_reset28)
  begin
    if (!n_reset28)
    begin
      sync_one    <= '0;
      sync_two    <= '0;
      input_value <= '0;
      input_prev  <= '0;
    end
    else
    begin
      sync_one    <= pin_in;
      sync_two    <= sync_one;
      input_value <= sync_two;
      input_prev  <= input_value;
    end
  end

  assign int_event   = input_value & ~input_prev;   // 0 -> 1 only
  assign int_trigger = int_event & direction_mode;  // outputs never interrupt

  // status read clears every bit, at end of setup
  assign status_clear = read & (addr == `GPR_INT_STATUS);

  // a new event in the clearing cycle still wins
  always_ff @(posedge pclk28 or negedge n_reset28)
  begin
    if (!n_reset28)
      int_status <= '0;
    else
      int_status <= (int_status & ~{`GPIO_BANK_W{status_clear}}) | int_trigger;
  end

  assign interrupt = int_status;

  // ---------------------------------------------------------------------------
  // read data, valid in access, zero otherwise
  // ---------------------------------------------------------------------------
  always_ff @(posedge pclk28 or negedge n_reset28)
  begin
    if (!n_reset28)
      rdata <= '0;
    else if (read)
    begin
      case (addr)
        `GPR_DIRECTION_MODE: rdata <= direction_mode;
        `GPR_OUTPUT_ENABLE:  rdata <= output_enable;
        `GPR_OUTPUT_VALUE:   rdata <= output_value;
        `GPR_INT_STATUS:     rdata <= int_status;      // value before clear
        default:             rdata <= input_value;     // input value and holes
      endcase
    end
    else
      rdata <= '0;
  end

  // pin drive
  assign pin_out  = output_value;
  assign pin_oe_n = ~(output_enable & ~direction_mode) | tri_state_enable;

endmodule

/* source/gpio_irq_ctrl.sv */
// gpio interrupt controller
// two-bit bank mask register, per-bank pending bits,
// combined interrupt output and register readback
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_irq_ctrl
  import gpio_pkg::*;
(
  input  logic        pclk28,
  input  logic        n_reset28,       // async, active low
  input  logic        read,
  input  logic        write,
  input  gpio_laddr_t addr,
  input  gpio_word_t  wdata,
  input  gpio_word_t  bank0_status,    // interrupt status of bank 0
  input  gpio_word_t  bank1_status,
  output gpio_word_t  rdata,
  output logic        irq
);

  logic [1:0] mask;      // bit n enables bank n
  logic [1:0] pending;   // any status bit set, per bank

  always_ff @(posedge pclk28 or negedge n_reset28)
  begin
    if (!n_reset28)
      mask <= 2'b00;
    else if (write && (addr == `GPR_IRQ_MASK))
      mask <= wdata[1:0];          // upper bits ignored
  end

  assign pending = {|bank1_status, |bank0_status};
  assign irq     = |(pending & mask);   // no register in the irq path

  // readback, zero when not strobed
  always_ff @(posedge pclk28 or negedge n_reset28)
  begin
    if (!n_reset28)
      rdata <= '0;
    else if (read && (addr == `GPR_IRQ_MASK))
      rdata <= {{(`GPIO_BANK_W-2){1'b0}}, mask};
    else if (read && (addr == `GPR_IRQ_PENDING))
      rdata <= {{(`GPIO_BANK_W-2){1'b0}}, pending};
    else
      rdata <= '0;                 // other offsets read zero
  end

endmodule

/* source/gpio_top.sv */
// gpio peripheral top level
// apb slave, two 16-pin banks and the interrupt controller
// bank 0 on pins 15:0, bank 1 on pins 31:16
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_top
  import gpio_pkg::*;
(
  input  logic                      pclk28,
  input  logic                      n_reset28,        // async, active low
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  gpio_paddr_t               paddr,
  input  gpio_word_t                pwdata,
  output gpio_word_t                prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic [2*`GPIO_BANK_W-1:0] pin_in,
  input  logic [2*`GPIO_BANK_W-1:0] tri_state_enable,
  output logic [2*`GPIO_BANK_W-1:0] pin_out,
  output logic [2*`GPIO_BANK_W-1:0] pin_oe_n,
  output logic                      irq
);

  // ---------------------------------------------------------------------------
  // local bus
  // ---------------------------------------------------------------------------
  gpio_laddr_t addr;
  gpio_word_t  wdata;
  gpio_word_t  bank0_rdata, bank1_rdata, irq_rdata;
  logic        bank0_read, bank0_write;
  logic        bank1_read, bank1_write;
  logic        irq_read, irq_write;
  gpio_word_t  bank0_status, bank1_status;   // to the irq controller

  gpio_apb_slave u_apb_slave (
    .pclk28, .n_reset28, .psel, .penable, .pwrite, .paddr, .pwdata,
    .bank0_rdata, .bank1_rdata, .irq_rdata,
    .prdata, .pready, .pslverr, .addr, .wdata,
    .bank0_read, .bank0_write, .bank1_read, .bank1_write,
    .irq_read, .irq_write
  );

  // ---------------------------------------------------------------------------
  // banks
  // ---------------------------------------------------------------------------
  gpio_lite_subunit u_bank0 (
    .pclk28, .n_reset28, .read(bank0_read), .write(bank0_write),
    .addr, .wdata,
    .pin_in(pin_in[`GPIO_BANK_W-1:0]),
    .tri_state_enable(tri_state_enable[`GPIO_BANK_W-1:0]),
    .interrupt(bank0_status), .rdata(bank0_rdata),
    .pin_oe_n(pin_oe_n[`GPIO_BANK_W-1:0]), .pin_out(pin_out[`GPIO_BANK_W-1:0])
  );

  gpio_lite_subunit u_bank1 (
    .pclk28, .n_reset28, .read(bank1_read), .write(bank1_write),
    .addr, .wdata,
    .pin_in(pin_in[2*`GPIO_BANK_W-1:`GPIO_BANK_W]),
    .tri_state_enable(tri_state_enable[2*`GPIO_BANK_W-1:`GPIO_BANK_W]),
    .interrupt(bank1_status), .rdata(bank1_rdata),
    .pin_oe_n(pin_oe_n[2*`GPIO_BANK_W-1:`GPIO_BANK_W]),
    .pin_out(pin_out[2*`GPIO_BANK_W-1:`GPIO_BANK_W])
  );

  gpio_irq_ctrl u_irq_ctrl (
    .pclk28, .n_reset28, .read(irq_read), .write(irq_write),
    .addr, .wdata, .bank0_status, .bank1_status,
    .rdata(irq_rdata), .irq
  );

endmodule

/* verification/gpio_chk.sv */
// concurrent checks for the gpio peripheral
// tri-state enable on the pin drive, irq source, apb response
// bound into every gpio_top instance
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_chk
  import gpio_pkg::*;
(
  input logic                      pclk28,
  input logic                      n_reset28,
  input logic                      psel,
  input logic                      penable,
  input gpio_paddr_t               paddr,
  input logic                      pready,
  input logic                      pslverr,
  input logic                      irq,
  input logic [2*`GPIO_BANK_W-1:0] tri_state_enable,
  input logic [2*`GPIO_BANK_W-1:0] pin_oe_n,
  input gpio_word_t                bank0_status,   // local wires of gpio_top
  input gpio_word_t                bank1_status
);

  int unsigned oe_fails;    // failure counts, summed at end of run
  int unsigned irq_fails;
  int unsigned bus_fails;

  // dft enable forces hi-z whatever the registers say
  oe_forced: assert property (@(posedge pclk28) disable iff (!n_reset28)
    (pin_oe_n & tri_state_enable) == tri_state_enable)
  else
  begin
    oe_fails++;
    $error("pin_oe_n driven on a pin with tri_state_enable set");
  end

  // no irq without some status bit behind it
  irq_source: assert property (@(posedge pclk28) disable iff (!n_reset28)
    irq |-> ((|bank0_status) || (|bank1_status)))
  else
  begin
    irq_fails++;
    $error("irq high with no interrupt status set in either bank");
  end

  // ready in every access cycle, error only for region 3
  bus_resp: assert property (@(posedge pclk28) disable iff (!n_reset28)
    (pready == (psel && penable)) &&
    (pslverr == (psel && penable && (paddr[`GPIO_PADDR_W-1 -: 2] == 2'b11))))
  else
  begin
    bus_fails++;
    $error("pready or pslverr wrong for the current apb phase");
  end

endmodule

bind gpio_top gpio_chk u_chk (.*);

/* verification/gpio_tb.sv */
// gpio peripheral testbench
// clock and reset, apb transfer tasks, reset values, register readback,
// pin drive, input path, edge interrupts, irq mask, unmapped region
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_tb
  import gpio_pkg::*;
();

  logic        pclk28, n_reset28, psel, penable, pwrite, pready, pslverr, irq;
  gpio_paddr_t paddr;
  gpio_word_t  pwdata, prdata;
  logic [31:0] pin_in, tri_state_enable, pin_out, pin_oe_n;
  gpio_word_t  rd;                      // prdata of the last transfer
  logic        err_seen;                // pslverr of the last transfer
  int          errors, timeouts;
  integer      seed = 32'h3728_1e45;

  gpio_top u_dut (.*);

  initial
  begin
    pclk28 = 1'b0;
    forever #10 pclk28 = ~pclk28;
  end

  // ---------------------------------------------------------------------------
  // bus helpers
  // ---------------------------------------------------------------------------
  function automatic gpio_paddr_t reg_addr(input logic [1:0] region, input gpio_laddr_t off);
    return {region, off};
  endfunction

  // pin by pin, hi-z unless an enabled output, dft enable always hi-z
  function automatic gpio_word_t expected_oe_n(input gpio_word_t dir, input gpio_word_t oe,
                                               input gpio_word_t tse);
    gpio_word_t e;
    for (int p = 0; p < `GPIO_BANK_W; p++)
    begin
      if (tse[p])
        e[p] = 1'b1;
      else if (!dir[p] && oe[p])
        e[p] = 1'b0;                    // output mode and enabled
      else
        e[p] = 1'b1;
    end
    return e;
  endfunction

  // setup then access, sampled mid low phase of access
  task automatic transfer(input logic wr, input gpio_paddr_t a, input gpio_word_t d);
    int n = 0;
    @(negedge pclk28);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    @(negedge pclk28);
    penable = 1'b1;
    #5;
    while (!pready && (n < 8))
    begin
      @(negedge pclk28);
      #5;
      n++;
    end
    if (!pready)
    begin
      timeouts++;
      $display("timeout: no pready for the transfer to address %h", a);
      finish_run();
    end
    else
    begin
      rd       = prdata;
      err_seen = pslverr;
      @(negedge pclk28);                // back to idle
      psel     = 1'b0;
      penable  = 1'b0;
    end
  endtask

  task automatic check(input string name, input gpio_word_t got, input gpio_word_t exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic write_reg(input gpio_paddr_t a, input gpio_word_t d);
    transfer(1'b1, a, d);
  endtask

  // read data plus the error response the region should give
  task automatic read_expect(input string name, input gpio_paddr_t a, input gpio_word_t exp);
    transfer(1'b0, a, '0);
    check(name, rd, exp);
    check({name, " pslverr"}, 16'(err_seen), 16'(a[7:6] == 2'b11));
  endtask

  task automatic finish_run;
    int unsigned asserts;
    asserts = u_dut.u_chk.oe_fails + u_dut.u_chk.irq_fails + u_dut.u_chk.bus_fails;
    $display("errors %0d  timeouts %0d  assertion failures %0d", errors, timeouts, asserts);
    if ((errors == 0) && (timeouts == 0) && (asserts == 0))
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial
  begin
    gpio_word_t dir, oe, val, tse;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = '0;
    pwdata           = '0;
    pin_in           = '0;
    tri_state_enable = '0;
    n_reset28        = 1'b0;
    repeat (3) @(negedge pclk28);
    n_reset28 = 1'b1;

    for (int i = 0; i < 3 * 64; i += 4)         // every offset of regions 0 to 2
      read_expect("reset value", 8'(i), '0);
    check("pin_oe_n bank0", pin_oe_n[15:0], 16'hFFFF);
    check("pin_oe_n bank1", pin_oe_n[31:16], 16'hFFFF);
    check("irq", 16'(irq), '0);

    for (int b = 0; b < 2; b++)
    begin
      dir = 16'($random(seed));
      oe  = 16'($random(seed));
      val = 16'($random(seed));
      tse = 16'($random(seed));
      write_reg(reg_addr(2'(b), `GPR_DIRECTION_MODE), dir);
      write_reg(reg_addr(2'(b), `GPR_OUTPUT_ENABLE), oe);
      write_reg(reg_addr(2'(b), `GPR_OUTPUT_VALUE), val);
      read_expect("direction_mode", reg_addr(2'(b), `GPR_DIRECTION_MODE), dir);
      read_expect("output_enable", reg_addr(2'(b), `GPR_OUTPUT_ENABLE), oe);
      read_expect("output_value", reg_addr(2'(b), `GPR_OUTPUT_VALUE), val);
      check("pin_out", pin_out[b*16 +: 16], val);
      tri_state_enable[b*16 +: 16] = tse;        // dft hi-z on random pins
      #5;
      check("pin_oe_n", pin_oe_n[b*16 +: 16], expected_oe_n(dir, oe, tse));
    end

    // input path, every pin an input
    write_reg(reg_addr(`GPIO_REGION_BANK0, `GPR_DIRECTION_MODE), '1);
    write_reg(reg_addr(`GPIO_REGION_BANK1, `GPR_DIRECTION_MODE), '1);
    repeat (4)
    begin
      pin_in = $random(seed);
      repeat (4) @(negedge pclk28);
      read_expect("input_value", reg_addr(`GPIO_REGION_BANK0, `GPR_INPUT_VALUE), pin_in[15:0]);
      read_expect("input_value", reg_addr(`GPIO_REGION_BANK1, `GPR_INPUT_VALUE), pin_in[31:16]);
    end

    // rising edges, low byte of bank 0 in input mode
    pin_in = '0;
    repeat (5) @(negedge pclk28);
    transfer(1'b0, reg_addr(`GPIO_REGION_BANK0, `GPR_INT_STATUS), '0);   // flush
    transfer(1'b0, reg_addr(`GPIO_REGION_BANK1, `GPR_INT_STATUS), '0);
    write_reg(reg_addr(`GPIO_REGION_BANK0, `GPR_DIRECTION_MODE), 16'h00FF);
    pin_in = 32'h0000_FFFF;
    repeat (5) @(negedge pclk28);
    read_expect("int_status", reg_addr(`GPIO_REGION_BANK0, `GPR_INT_STATUS), 16'h00FF);
    read_expect("int_status", reg_addr(`GPIO_REGION_BANK0, `GPR_INT_STATUS), '0);
    pin_in = '0;                                  // falling edges only
    repeat (5) @(negedge pclk28);
    read_expect("int_status", reg_addr(`GPIO_REGION_BANK0, `GPR_INT_STATUS), '0);

    // one pending bit in bank 1, walk the mask
    pin_in = 32'h0001_0000;
    repeat (5) @(negedge pclk28);
    read_expect("irq_pending", reg_addr(`GPIO_REGION_IRQ, `GPR_IRQ_PENDING), 16'h0002);
    for (int m = 0; m < 4; m++)
    begin
      write_reg(reg_addr(`GPIO_REGION_IRQ, `GPR_IRQ_MASK), 16'(m));
      read_expect("irq_mask", reg_addr(`GPIO_REGION_IRQ, `GPR_IRQ_MASK), 16'(m));
      check("irq", 16'(irq), 16'(m[1]));
    end
    read_expect("int_status", reg_addr(`GPIO_REGION_BANK1, `GPR_INT_STATUS), 16'h0001);
    check("irq", 16'(irq), '0);

    // region 3 is unmapped
    write_reg(8'hC4, 16'hFFFF);
    check("pslverr", 16'(err_seen), 16'h0001);
    read_expect("unmapped read", 8'hC4, '0);
    read_expect("direction_mode", reg_addr(`GPIO_REGION_BANK0, `GPR_DIRECTION_MODE), 16'h00FF);
    read_expect("direction_mode", reg_addr(`GPIO_REGION_BANK1, `GPR_DIRECTION_MODE), 16'hFFFF);
    read_expect("irq_mask", reg_addr(`GPIO_REGION_IRQ, `GPR_IRQ_MASK), 16'h0003);
    finish_run();
  end

endmodule

/* vlog.f */
+incdir+include
source/gpio_pkg.sv
source/gpio_apb_slave.sv
source/gpio_lite_subunit.sv
source/gpio_irq_ctrl.sv
source/gpio_top.sv
verification/gpio_chk.sv
verification/gpio_tb.sv

/* Makefile */
# verilator build and run for the gpio peripheral
VERILATOR ?= verilator
TOP       ?= gpio_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --top-module $(TOP)
SIMARGS   ?= +verilator+error+limit+1000

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(SIMARGS) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	grep -q '^sim passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
